// File: Makefile
# Verilator flow for the SPI command interpreter testbench
VERILATOR ?= verilator
TOP       ?= spi_cmd_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line counts as a failure
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
	    echo "Simulation FAILED"; exit 1; \
	elif grep -q "All tests passed!" $(LOG); then \
	    echo "Simulation PASSED"; \
	else \
	    echo "Simulation gave no result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/cdc_sync.sv
`timescale 1ns/1ps

module cdc_sync (
    input  logic                  SCK,
    input  logic                  NRST,
    input  spi_cmd_pkg::sync_in_t async_in,
    output spi_cmd_pkg::sync_in_t sync_out
);

    // First stage may go metastable
    spi_cmd_pkg::sync_in_t meta_q;
    // Second stage is safe to use on SCK
    spi_cmd_pkg::sync_in_t sync_q;

    // Status, temperature and ensamp all go through the same chain
    // Multi-bit fields are assumed quasi-static at the source
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= async_in;
            sync_q <= meta_q;
        end
    end

    // Two edges from input change to output
    assign sync_out = sync_q;

endmodule

// File: source/cmd_fsm.sv
`timescale 1ns/1ps

module cmd_fsm (
    input  logic                    SCK,
    input  logic                    NRST,
    input  logic                    cs,
    input  spi_cmd_pkg::spi_rx_t    rx,
    output spi_cmd_pkg::cmd_state_t state,
    output spi_cmd_pkg::reg_addr_t  reg_addr
);

    spi_cmd_pkg::cmd_state_t state_q;
    spi_cmd_pkg::cmd_state_t state_nxt;
    spi_cmd_pkg::cmd_op_t    op;
    spi_cmd_pkg::reg_addr_t  addr_q;
    logic                    addr_zero;
    logic                    first_transaction;

    // Opcode and address field of the command byte
    assign op        = spi_cmd_pkg::cmd_op_t'(rx.cmd_byte[7:6]);
    assign addr_zero = (rx.cmd_byte[5:0] == 6'd0);

    // Set while CS is high, cleared by the first command byte
    always_ff @(posedge SCK or negedge NRST or posedge cs) begin
        if (!NRST || cs) begin
            first_transaction <= 1'b1;
        end else if (rx.byte_rcvd) begin
            first_transaction <= 1'b0;
        end
    end

    ////////////////////
    // Next-state logic
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            spi_cmd_pkg::IDLE: begin
                if (rx.byte_rcvd) begin
                    case (op)
                        spi_cmd_pkg::RDREG:  state_nxt = spi_cmd_pkg::READ_REG;
                        spi_cmd_pkg::WRREG:  state_nxt = spi_cmd_pkg::WRITE_REG;
                        // Data and CRC reads carry no address
                        spi_cmd_pkg::RDDATA: if (addr_zero) state_nxt = spi_cmd_pkg::READ_DATA;
                        spi_cmd_pkg::RDCRC:  if (addr_zero) state_nxt = spi_cmd_pkg::READ_CRC;
                        default:             state_nxt = spi_cmd_pkg::IDLE;
                    endcase
                end
            end
            spi_cmd_pkg::READ_REG,
            spi_cmd_pkg::WRITE_REG,
            spi_cmd_pkg::READ_CRC: begin
                // Single-frame commands
                if (rx.word_rcvd || first_transaction) begin
                    state_nxt = spi_cmd_pkg::IDLE;
                end
            end
            spi_cmd_pkg::READ_DATA: begin
                // Burst runs until CS rises
                if (first_transaction) begin
                    state_nxt = spi_cmd_pkg::IDLE;
                end
            end
            default: state_nxt = spi_cmd_pkg::IDLE;
        endcase
    end

    // State register, forced to IDLE while deselected
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            state_q <= spi_cmd_pkg::IDLE;
        end else if (cs) begin
            state_q <= spi_cmd_pkg::IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    // Address field captured with the command byte
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            addr_q <= '0;
        end else if (rx.byte_rcvd && (state_q == spi_cmd_pkg::IDLE)) begin
            addr_q <= rx.cmd_byte[5:0];
        end
    end

    assign state    = state_q;
    assign reg_addr = addr_q;

endmodule

// File: source/fifo_readout.sv
`timescale 1ns/1ps

module fifo_readout #(
    parameter int WORDS_PER_SAMPLE = 8
) (
    input  logic                              SCK,
    input  logic                              NRST,
    input  logic                              cs,
    input  spi_cmd_pkg::cmd_state_t           state,
    input  spi_cmd_pkg::spi_rx_t              rx,
    input  logic [WORDS_PER_SAMPLE*16-1:0]    adc_data,
    output spi_cmd_pkg::tx_word_t             data_word,
    output logic                              fifo_pop,
    output spi_cmd_pkg::tx_word_t             crc
);

    // At least one index bit even for single-word samples
    localparam int IDX_W = (WORDS_PER_SAMPLE > 1) ? $clog2(WORDS_PER_SAMPLE) : 1;

    logic [IDX_W-1:0]      word_idx;
    logic                  in_burst;
    logic                  word_tick;
    logic                  last_word;
    logic                  burst_started;
    logic                  pop_q;
    spi_cmd_pkg::tx_word_t crc_q;

    // MSB-first CRC-16-CCITT over one word
    function automatic spi_cmd_pkg::tx_word_t crc_next(spi_cmd_pkg::tx_word_t crc_in,
                                                        spi_cmd_pkg::tx_word_t data);
        spi_cmd_pkg::tx_word_t c;
        c = crc_in;
        for (int i = 15; i >= 0; i--) begin
            if (c[15] ^ data[i]) begin
                c = {c[14:0], 1'b0} ^ spi_cmd_pkg::CRC_POLY;
            end else begin
                c = {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    assign in_burst  = (state == spi_cmd_pkg::READ_DATA);
    assign word_tick = in_burst && rx.word_rcvd;
    assign last_word = (word_idx == IDX_W'(WORDS_PER_SAMPLE - 1));

    // Word 0 is the lowest 16 bits of the sample
    assign data_word = adc_data[{word_idx, 4'b0000} +: 16];

    ////////////////////
    // Word counter
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            word_idx <= '0;
        end else if (!in_burst || cs) begin
            word_idx <= '0;
        end else if (word_tick) begin
            // Wrap onto the next sample
            word_idx <= last_word ? '0 : word_idx + 1'b1;
        end
    end

    // Pop after the last word, or when CS cuts a partial burst
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= (word_tick && last_word) || (in_burst && cs && (word_idx != '0));
        end
    end

    ////////////////////
    // CRC accumulator
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            crc_q         <= spi_cmd_pkg::CRC_INIT;
            burst_started <= 1'b0;
        end else if (word_tick) begin
            // Fresh seed on the first word of a burst
            crc_q         <= crc_next(burst_started ? crc_q : spi_cmd_pkg::CRC_INIT, data_word);
            burst_started <= 1'b1;
        end else if (!in_burst) begin
            // Value held for RDCRC
            burst_started <= 1'b0;
        end
    end

    assign fifo_pop = pop_q;
    assign crc      = crc_q;

endmodule

// File: source/reg_access.sv
`timescale 1ns/1ps

module reg_access (
    input  logic                    SCK,
    input  logic                    NRST,
    input  spi_cmd_pkg::cmd_state_t state,
    input  spi_cmd_pkg::reg_addr_t  reg_addr,
    input  spi_cmd_pkg::spi_rx_t    rx,
    input  spi_cmd_pkg::sync_in_t   sync,
    input  spi_cmd_pkg::cfg_bus_t   cfg_data,
    output spi_cmd_pkg::cfg_wr_t    cfg_wr,
    output spi_cmd_pkg::reg_byte_t  rd_byte
);

    logic                   is_cfg;
    logic                   wr_ok;
    logic                   wr_en_q;
    spi_cmd_pkg::reg_addr_t wr_addr_q;
    spi_cmd_pkg::reg_byte_t wr_value_q;

    // Physical config bytes run from 0 to the last address
    assign is_cfg = (reg_addr <= spi_cmd_pkg::CFG_LAST_ADDR);

    // Sampling locks all config bytes but the last one
    assign wr_ok = is_cfg &&
                   (!sync.ensamp || (reg_addr == spi_cmd_pkg::CFG_LAST_ADDR));

    ////////////////////
    // Write path
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            wr_en_q <= 1'b0;
        end else begin
            // One-cycle strobe after the data frame
            wr_en_q <= (state == spi_cmd_pkg::WRITE_REG) && rx.word_rcvd && wr_ok;
        end
    end

    // Address and value held with the strobe
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            wr_addr_q  <= '0;
            wr_value_q <= '0;
        end else if ((state == spi_cmd_pkg::WRITE_REG) && rx.word_rcvd && wr_ok) begin
            wr_addr_q  <= reg_addr;
            wr_value_q <= rx.data_byte;
        end
    end

    assign cfg_wr.reg_addr  = wr_addr_q;
    assign cfg_wr.reg_value = wr_value_q;
    assign cfg_wr.wr_en     = wr_en_q;

    ////////////////////
    // Read multiplexer
    always_comb begin
        rd_byte = '0;
        if (is_cfg) begin
            rd_byte = cfg_data[{reg_addr, 3'b000} +: 8];
        end else begin
            case (reg_addr)
                spi_cmd_pkg::ADDR_STATUS_LO: rd_byte = sync.status[7:0];
                // Upper six flags with zero extension
                spi_cmd_pkg::ADDR_STATUS_HI: rd_byte = {2'b00, sync.status[13:8]};
                spi_cmd_pkg::ADDR_TEMP_HI:   rd_byte = sync.tempval[15:8];
                spi_cmd_pkg::ADDR_TEMP_LO:   rd_byte = sync.tempval[7:0];
                // Unmapped reads give zero
                default:                     rd_byte = '0;
            endcase
        end
    end

endmodule

// File: source/spi_cmd_interp.sv
`timescale 1ns/1ps

module spi_cmd_interp #(
    parameter int WORDS_PER_SAMPLE = 8
) (
    input  logic                           SCK,
    input  logic                           NRST,
    input  logic                           cs,
    input  spi_cmd_pkg::spi_rx_t           rx,
    output spi_cmd_pkg::tx_word_t          tx_buff,
    input  logic [WORDS_PER_SAMPLE*16-1:0] adc_data,
    output logic                           fifo_pop,
    input  spi_cmd_pkg::cfg_bus_t          cfg_data,
    output spi_cmd_pkg::cfg_wr_t           cfg_wr,
    input  spi_cmd_pkg::sync_in_t          async_in
);

    spi_cmd_pkg::sync_in_t   sync;
    spi_cmd_pkg::cmd_state_t state;
    spi_cmd_pkg::reg_addr_t  reg_addr;
    spi_cmd_pkg::reg_byte_t  rd_byte;
    spi_cmd_pkg::tx_word_t   data_word;
    spi_cmd_pkg::tx_word_t   crc;

    // Slow-domain inputs onto SCK
    cdc_sync cdc_sync_i (.SCK(SCK), .NRST(NRST), .async_in(async_in), .sync_out(sync));

    cmd_fsm cmd_fsm_i (
        .SCK(SCK), .NRST(NRST), .cs(cs), .rx(rx), .state(state), .reg_addr(reg_addr)
    );

    reg_access reg_access_i (
        .SCK(SCK), .NRST(NRST), .state(state), .reg_addr(reg_addr), .rx(rx),
        .sync(sync), .cfg_data(cfg_data), .cfg_wr(cfg_wr), .rd_byte(rd_byte)
    );

    fifo_readout #(.WORDS_PER_SAMPLE(WORDS_PER_SAMPLE)) fifo_readout_i (
        .SCK(SCK), .NRST(NRST), .cs(cs), .state(state), .rx(rx), .adc_data(adc_data),
        .data_word(data_word), .fifo_pop(fifo_pop), .crc(crc)
    );

    ////////////////////
    // Response word, no added latency
    always_comb begin
        case (state)
            spi_cmd_pkg::READ_REG:  tx_buff = {spi_cmd_pkg::RESP_REGDATA, rd_byte};
            spi_cmd_pkg::READ_DATA: tx_buff = data_word;
            spi_cmd_pkg::READ_CRC:  tx_buff = crc;
            // IDLE and write ack send the status flags
            default:                tx_buff = {sync.status, spi_cmd_pkg::RESP_STATUS};
        endcase
    end

endmodule

// File: source/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // Opcode field, bits 7..6 of the command byte
    typedef enum logic [1:0] {
        RDREG  = 2'b00,
        RDCRC  = 2'b01,
        WRREG  = 2'b10,
        RDDATA = 2'b11
    } cmd_op_t;

    // One-hot interpreter states
    typedef enum logic [4:0] {
        IDLE      = 5'b00001,
        READ_REG  = 5'b00010,
        WRITE_REG = 5'b00100,
        READ_DATA = 5'b01000,
        READ_CRC  = 5'b10000
    } cmd_state_t;

    typedef logic [5:0]   reg_addr_t;
    typedef logic [7:0]   reg_byte_t;
    typedef logic [15:0]  tx_word_t;
    typedef logic [13:0]  status_t;
    typedef logic [15:0]  temp_t;
    // Byte n of the config image sits at bits 8n upward
    typedef logic [511:0] cfg_bus_t;

    // Strobes and bytes from the SPI core
    typedef struct packed {
        logic      byte_rcvd;
        logic      word_rcvd;
        reg_byte_t cmd_byte;
        reg_byte_t data_byte;
    } spi_rx_t;

    // Write port towards the register file
    typedef struct packed {
        reg_addr_t reg_addr;
        reg_byte_t reg_value;
        logic      wr_en;
    } cfg_wr_t;

    // Group crossing in from the sampling clock domain
    typedef struct packed {
        status_t status;
        temp_t   tempval;
        logic    ensamp;
    } sync_in_t;

    ////////////////////
    // Response headers
    localparam logic [7:0] RESP_REGDATA = 8'hC0;
    localparam logic [1:0] RESP_STATUS  = 2'b01;

    ////////////////////
    // Address map
    localparam reg_addr_t CFG_LAST_ADDR  = 6'h23;
    localparam reg_addr_t ADDR_STATUS_LO = 6'h24;
    localparam reg_addr_t ADDR_STATUS_HI = 6'h25;
    localparam reg_addr_t ADDR_TEMP_HI   = 6'h2C;
    localparam reg_addr_t ADDR_TEMP_LO   = 6'h2D;

    // CRC-16-CCITT
    localparam tx_word_t CRC_POLY = 16'h1021;
    localparam tx_word_t CRC_INIT = 16'hFFFF;

endpackage

// File: verification/spi_cmd_asserts.sv
`timescale 1ns/1ps

module spi_cmd_asserts (
    input logic                    SCK,
    input logic                    NRST,
    input logic                    cs,
    input spi_cmd_pkg::cmd_state_t state,
    input spi_cmd_pkg::cfg_wr_t    cfg_wr,
    input logic                    fifo_pop
);

    // Register file write strobe is a single pulse
    wr_en_pulse: assert property (@(posedge SCK) disable iff (!NRST)
        cfg_wr.wr_en |=> !cfg_wr.wr_en)
        else $error("cfg_wr.wr_en high for more than one cycle");

    // One pop per burst, never a held level
    fifo_pop_pulse: assert property (@(posedge SCK) disable iff (!NRST)
        fifo_pop |=> !fifo_pop)
        else $error("fifo_pop high for more than one cycle");

    // State encoding stays one-hot
    state_onehot: assert property (@(posedge SCK) disable iff (!NRST)
        $onehot(state))
        else $error("FSM state is not one-hot");

    // Deselect forces the FSM home
    cs_idle: assert property (@(posedge SCK) disable iff (!NRST)
        cs |=> (state == spi_cmd_pkg::IDLE))
        else $error("FSM not in IDLE one edge after CS high");

endmodule

bind spi_cmd_interp spi_cmd_asserts spi_cmd_asserts_i (
    .SCK(SCK), .NRST(NRST), .cs(cs), .state(state), .cfg_wr(cfg_wr), .fifo_pop(fifo_pop)
);

// File: verification/spi_cmd_patterns.txt
// Columns (hex): test id, command byte, data byte, ensamp, status, temperature, expected
// Expected: read word for RDREG, wr_en pulses for WRREG, pops for RDDATA, unused for RDCRC
01 10 00 0 0123 0456 C090
02 85 3C 0 0123 0456 0001
03 05 00 0 0123 0456 C03C
04 80 A7 0 0123 0456 0001
05 00 00 0 0123 0456 C0A7
06 A3 5E 0 0123 0456 0001
07 23 00 0 0123 0456 C05E
08 85 99 1 0123 0456 0000
09 05 00 1 0123 0456 C03C
0A A3 6D 1 0123 0456 0001
0B 23 00 1 0123 0456 C06D
0C A4 FF 0 0123 0456 0000
0D 24 00 0 1A5C 7E31 C05C
0E 25 00 0 1A5C 7E31 C01A
0F 2C 00 0 1A5C 7E31 C07E
10 2D 00 0 1A5C 7E31 C031
11 30 00 0 1A5C 7E31 C000
12 C0 08 0 2B07 0456 0001
13 40 00 0 2B07 0456 0000
14 C0 03 0 2B07 0456 0001
15 40 00 0 2B07 0456 0000
16 C0 08 1 2B07 0456 0001
17 40 00 1 2B07 0456 0000
18 3F 00 0 0123 0456 C000
19 BF 55 0 0123 0456 0000

// File: verification/spi_cmd_tb.sv
`timescale 1ns/1ps

module spi_cmd_tb;

    localparam int WORDS_PER_SAMPLE = 8;
    localparam int NUM_PATS         = 25;
    localparam int PAT_COLS         = 7;
    localparam int CLK_PERIOD       = 20;
    localparam int DRIVE_DLY        = 2;
    localparam int SEED             = 24862;

    logic                           SCK;
    logic                           NRST;
    logic                           cs;
    spi_cmd_pkg::spi_rx_t           rx;
    spi_cmd_pkg::tx_word_t          tx_buff;
    logic [WORDS_PER_SAMPLE*16-1:0] adc_data;
    logic                           fifo_pop;
    spi_cmd_pkg::cfg_bus_t          cfg_data;
    spi_cmd_pkg::cfg_wr_t           cfg_wr;
    spi_cmd_pkg::sync_in_t          async_in;

    logic [15:0] pat_mem [0:NUM_PATS*PAT_COLS-1];
    logic [15:0] rx_words [$];
    logic [15:0] last_crc;
    int          err_count;
    int          pass_tests;
    int          fail_tests;
    int          wr_count;
    int          pop_count;

    spi_cmd_interp #(.WORDS_PER_SAMPLE(WORDS_PER_SAMPLE)) spi_cmd_interp_i (
        .SCK(SCK), .NRST(NRST), .cs(cs), .rx(rx), .tx_buff(tx_buff), .adc_data(adc_data),
        .fifo_pop(fifo_pop), .cfg_data(cfg_data), .cfg_wr(cfg_wr), .async_in(async_in)
    );

    initial begin
        SCK = 1'b0;
        forever #(CLK_PERIOD / 2) SCK = ~SCK;
    end

    ////////////////////
    // Bench models

    // Fresh random ADC sample
    function automatic logic [WORDS_PER_SAMPLE*16-1:0] next_sample();
        logic [WORDS_PER_SAMPLE*16-1:0] s;
        for (int k = 0; k < WORDS_PER_SAMPLE / 2; k++) begin
            s[32*k +: 32] = $urandom();
        end
        return s;
    endfunction

    // FIFO always shows a sample and steps to the next one after each pop
    initial begin
        void'($urandom(SEED));
        adc_data = next_sample();
        forever begin
            @(posedge SCK);
            #DRIVE_DLY;
            if (fifo_pop) begin
                adc_data = next_sample();
            end
        end
    end

    // Register file model whose power-up bytes follow the address
    initial begin
        for (int n = 0; n < 64; n++) begin
            cfg_data[8*n +: 8] = 8'h80 + 8'(n);
        end
        forever begin
            @(posedge SCK);
            #DRIVE_DLY;
            if (cfg_wr.wr_en) begin
                cfg_data[{cfg_wr.reg_addr, 3'b000} +: 8] = cfg_wr.reg_value;
            end
        end
    end

    // Strobe counters
    always @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            wr_count  <= 0;
            pop_count <= 0;
        end else begin
            if (cfg_wr.wr_en) wr_count <= wr_count + 1;
            if (fifo_pop) pop_count <= pop_count + 1;
        end
    end

    // CRC-16-CCITT over one byte MSB first
    function automatic logic [15:0] crc_add_byte(input logic [15:0] crc_in, input logic [7:0] b);
        logic [15:0] c;
        c = crc_in ^ {b, 8'h00};
        for (int k = 0; k < 8; k++) begin
            if (c[15]) begin
                c = {c[14:0], 1'b0} ^ 16'h1021;
            end else begin
                c = {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s = %h, expected %h", $time, name, actual, expected);
            err_count++;
        end
    endtask

    ////////////////////
    // SPI core model
    task automatic spi_transfer(input logic [7:0] cmd, input logic [7:0] data, input int words,
                                input logic [15:0] idle_word);
        rx_words.delete();
        @(posedge SCK);
        #DRIVE_DLY;
        cs          = 1'b0;
        rx.cmd_byte = cmd;
        // Selected but no command yet
        @(negedge SCK);
        check_value("tx_buff (idle)", tx_buff, idle_word);
        @(posedge SCK);
        #DRIVE_DLY;
        rx.byte_rcvd = 1'b1;
        @(posedge SCK);
        #DRIVE_DLY;
        rx.byte_rcvd = 1'b0;
        for (int w = 0; w < words; w++) begin
            repeat (3) @(posedge SCK);
            // Word that goes out with this frame
            @(negedge SCK);
            rx_words.push_back(tx_buff);
            @(posedge SCK);
            #DRIVE_DLY;
            rx.data_byte = data;
            rx.word_rcvd = 1'b1;
            @(posedge SCK);
            #DRIVE_DLY;
            rx.word_rcvd = 1'b0;
        end
        repeat (2) @(posedge SCK);
        #DRIVE_DLY;
        cs = 1'b1;
        repeat (4) @(posedge SCK);
    endtask

    task automatic run_pattern(input int p);
        logic [15:0]                    id;
        logic [15:0]                    cmd;
        logic [15:0]                    data;
        logic [15:0]                    expected;
        logic [15:0]                    status_word;
        logic [WORDS_PER_SAMPLE*16-1:0] sample;
        int                             errs_before;
        int                             wr_before;
        int                             pop_before;
        int                             nwords;
        id          = pat_mem[p*PAT_COLS];
        cmd         = pat_mem[p*PAT_COLS+1];
        data        = pat_mem[p*PAT_COLS+2];
        expected    = pat_mem[p*PAT_COLS+6];
        errs_before = err_count;
        // Slow-domain inputs and settle time for the synchronizer
        @(posedge SCK);
        #DRIVE_DLY;
        async_in.ensamp  = pat_mem[p*PAT_COLS+3][0];
        async_in.status  = pat_mem[p*PAT_COLS+4][13:0];
        async_in.tempval = pat_mem[p*PAT_COLS+5];
        repeat (4) @(posedge SCK);
        status_word = {pat_mem[p*PAT_COLS+4][13:0], 2'b01};
        // Bursts take the word count from the data column
        nwords      = (cmd[7:6] == 2'b11) ? int'(data[7:0]) : 1;
        wr_before   = wr_count;
        pop_before  = pop_count;
        sample      = adc_data;
        spi_transfer(cmd[7:0], data[7:0], nwords, status_word);
        case (cmd[7:6])
            2'b00: check_value("tx_buff (reg read)", rx_words[0], expected);
            2'b10: begin
                // Write frame answers with status
                check_value("tx_buff (write)", rx_words[0], status_word);
                check_value("cfg_wr.wr_en pulses", 16'(wr_count - wr_before), expected);
            end
            2'b11: begin
                for (int w = 0; w < nwords; w++) begin
                    check_value("tx_buff (data word)", rx_words[w], sample[16*w +: 16]);
                end
                check_value("fifo_pop pulses", 16'(pop_count - pop_before), expected);
                // Reference CRC over the words seen with the high byte first
                last_crc = 16'hFFFF;
                foreach (rx_words[w]) begin
                    last_crc = crc_add_byte(last_crc, rx_words[w][15:8]);
                    last_crc = crc_add_byte(last_crc, rx_words[w][7:0]);
                end
            end
            default: check_value("tx_buff (crc)", rx_words[0], last_crc);
        endcase
        if (err_count == errs_before) begin
            pass_tests++;
            $display("Test %h cmd %h: ok", id[7:0], cmd[7:0]);
        end else begin
            fail_tests++;
            $display("Test %h cmd %h: FAILED, %0d mismatches", id[7:0], cmd[7:0],
                     err_count - errs_before);
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        NRST       = 1'b0;
        cs         = 1'b1;
        rx         = '0;
        async_in   = '0;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        last_crc   = 16'hFFFF;
        $readmemh("verification/spi_cmd_patterns.txt", pat_mem);
        if (pat_mem[0] !== 16'h0001) begin
            $display("Pattern file did not load, first test id reads %h", pat_mem[0]);
            err_count++;
        end
        repeat (4) @(posedge SCK);
        #DRIVE_DLY;
        NRST = 1'b1;
        repeat (2) @(posedge SCK);
        for (int p = 0; p < NUM_PATS; p++) begin
            run_pattern(p);
        end
        $display("Tests: %0d run, %0d ok, %0d failed, %0d mismatches", NUM_PATS, pass_tests,
                 fail_tests, err_count);
        if ((err_count == 0) && (fail_tests == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog allows 200 cycles per pattern
    initial begin
        #(NUM_PATS * 200 * CLK_PERIOD);
        $display("Timeout, the run did not finish within %0d cycles", NUM_PATS * 200);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog.f
source/spi_cmd_pkg.sv
source/cdc_sync.sv
source/cmd_fsm.sv
source/reg_access.sv
source/fifo_readout.sv
source/spi_cmd_interp.sv
verification/spi_cmd_asserts.sv
verification/spi_cmd_tb.sv
